// File: source/sysctl_cfg_pkg.sv
`default_nettype none

package sysctl_cfg_pkg;

    // Stabilized board inputs
    localparam int SYNC_WIDTH = 9;

    // Bit positions inside the stabilizer vector
    localparam int SYNC_NRESET      = 0;
    localparam int SYNC_DTR         = 1;
    localparam int SYNC_SPI1_NINT   = 2;
    localparam int SYNC_SPI2_NINT   = 3;
    localparam int SYNC_SPI3_INT    = 4;
    localparam int SYNC_SPI4_GP     = 5;
    localparam int SYNC_FRAME_DRAWN = 6;
    localparam int SYNC_BOOT_MODE   = 7;
    localparam int SYNC_SELECT_HDMI = 8;

    // Bus sizes of the surrounding computer
    localparam int PC_WIDTH   = 27;
    localparam int VRAM_COUNT = 4;

    // About 2 ms at 50 MHz, long enough to see a blink
    localparam int DEFAULT_LED_MIN_CYCLES   = 100000;
    localparam int DEFAULT_DTR_PULSE_CYCLES = 64;

    // First address past the bootloader
    localparam logic [PC_WIDTH-1:0] DEFAULT_BOOT_DONE_PC = 27'hC02522;

endpackage

`default_nettype wire

// File: source/sysctl_state_pkg.sv
`default_nettype none

package sysctl_state_pkg;

    // Serial-port reset pulse FSM
    typedef enum logic [1:0] {
        DTR_IDLE     = 2'd0,
        DTR_PULSE    = 2'd1,
        DTR_WAIT_LOW = 2'd2
    } dtr_state_t;

    // Activity LED stretcher FSM
    typedef enum logic [1:0] {
        LED_IDLE     = 2'd0,
        LED_ON       = 2'd1,
        LED_HOLD_OFF = 2'd2
    } led_state_t;

endpackage

`default_nettype wire

// File: source/input_stabilizer.sv
`timescale 1ns/1ps
`default_nettype none

module input_stabilizer
    import sysctl_cfg_pkg::*;
#(
    parameter int WIDTH = SYNC_WIDTH
) (
    input  wire              clk,
    input  wire              rst_n,
    input  wire  [WIDTH-1:0] async_in,
    output logic [WIDTH-1:0] stable_out
);

    // First stage may go metastable, second stage settles it
    logic [WIDTH-1:0] meta_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            meta_q     <= '0;
            stable_out <= '0;
        end else begin
            meta_q     <= async_in;
            stable_out <= meta_q;
        end
    end

    // Fixed latency of two edges once both stages hold sampled data
    assert property (
        @(posedge clk) disable iff (!rst_n)
        $past(rst_n, 1) && $past(rst_n, 2) |-> stable_out == $past(async_in, 2)
    )
    else $error("input_stabilizer: output does not match input from two cycles ago");

endmodule

`default_nettype wire

// File: source/dtr_reset_pulse.sv
`timescale 1ns/1ps
`default_nettype none

module dtr_reset_pulse
    import sysctl_state_pkg::*;
#(
    parameter int PULSE_CYCLES = 64
) (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  dtr,
    output logic dtr_reset
);

    localparam int CNT_W = $clog2(PULSE_CYCLES + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(PULSE_CYCLES - 1);

    dtr_state_t       state;
    logic             dtr_q;
    logic [CNT_W-1:0] cnt;
    logic             dtr_rise;

    // Port opening shows as a rising DTR line
    assign dtr_rise = dtr && !dtr_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= DTR_IDLE;
            dtr_q     <= 1'b0;
            cnt       <= '0;
            dtr_reset <= 1'b0;
        end else begin
            dtr_q <= dtr;
            case (state)
                DTR_IDLE: begin
                    if (dtr_rise) begin
                        state     <= DTR_PULSE;
                        cnt       <= '0;
                        dtr_reset <= 1'b1;
                    end
                end
                DTR_PULSE: begin
                    if (cnt == CNT_LAST) begin
                        state     <= DTR_WAIT_LOW;
                        dtr_reset <= 1'b0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                DTR_WAIT_LOW: begin
                    // One pulse per port opening
                    if (!dtr) begin
                        state <= DTR_IDLE;
                    end
                end
                default: begin
                    state     <= DTR_IDLE;
                    dtr_reset <= 1'b0;
                end
            endcase
        end
    end

    assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(dtr_reset) |-> ##PULSE_CYCLES !dtr_reset
    )
    else $error("dtr_reset_pulse: reset pulse longer than PULSE_CYCLES");

    assert property (@(posedge clk) disable iff (!rst_n) dtr_reset == (state == DTR_PULSE))
    else $error("dtr_reset_pulse: output out of step with FSM state");

endmodule

`default_nettype wire

// File: source/activity_led.sv
`timescale 1ns/1ps
`default_nettype none

module activity_led
    import sysctl_state_pkg::*;
#(
    parameter int MIN_CYCLES = 100000
) (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  activity,
    output logic led_n
);

    localparam int CNT_W = $clog2(MIN_CYCLES + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(MIN_CYCLES - 1);

    led_state_t       state;
    logic [CNT_W-1:0] cnt;
    logic             cnt_done;

    assign cnt_done = (cnt == CNT_LAST);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= LED_IDLE;
            cnt   <= '0;
            led_n <= 1'b1;
        end else begin
            case (state)
                LED_IDLE: begin
                    if (activity) begin
                        state <= LED_ON;
                        cnt   <= '0;
                        led_n <= 1'b0;
                    end
                end
                LED_ON: begin
                    // New activity while lit does not extend the blink
                    if (cnt_done) begin
                        state <= LED_HOLD_OFF;
                        cnt   <= '0;
                        led_n <= 1'b1;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                LED_HOLD_OFF: begin
                    // Dark gap so steady traffic still blinks
                    if (cnt_done) begin
                        state <= LED_IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    state <= LED_IDLE;
                    led_n <= 1'b1;
                end
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) !led_n |-> state == LED_ON)
    else $error("activity_led: LED lit outside of LED_ON");

endmodule

`default_nettype wire

// File: source/status_led_bank.sv
`timescale 1ns/1ps
`default_nettype none

module status_led_bank
    import sysctl_cfg_pkg::*;
#(
    parameter int                  LED_MIN_CYCLES = DEFAULT_LED_MIN_CYCLES,
    parameter logic [PC_WIDTH-1:0] BOOT_DONE_PC   = DEFAULT_BOOT_DONE_PC
) (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  sys_reset,
    input  wire  [PC_WIDTH-1:0]  pc,
    input  wire                  usb0_cs_n,
    input  wire                  usb1_cs_n,
    input  wire                  eth_cs_n,
    input  wire                  flash_cs_n,
    input  wire                  ps2_int,
    input  wire  [VRAM_COUNT-1:0] vram_we,
    input  wire                  select_hdmi,
    input  wire                  qspi_mode,
    output logic                 led_usb0_n,
    output logic                 led_usb1_n,
    output logic                 led_eth_n,
    output logic                 led_flash_n,
    output logic                 led_ps2_n,
    output logic                 led_gpu_n,
    output logic                 led_booted_n,
    output logic                 led_hdmi_n,
    output logic                 led_qspi_n
);

    localparam int NUM_ACT = 6;

    logic [NUM_ACT-1:0] act;
    logic [NUM_ACT-1:0] act_led_n;

    // Chip selects are active low, activity is active high
    assign act[0] = !usb0_cs_n;
    assign act[1] = !usb1_cs_n;
    assign act[2] = !eth_cs_n;
    assign act[3] = !flash_cs_n;
    assign act[4] = ps2_int;
    // Any VRAM write counts as GPU traffic
    assign act[5] = |vram_we;

    for (genvar i = 0; i < NUM_ACT; i++) begin : gen_act_led
        activity_led #(
            .MIN_CYCLES (LED_MIN_CYCLES)
        ) u_activity_led (
            .clk      (clk),
            .rst_n    (rst_n),
            .activity (act[i]),
            .led_n    (act_led_n[i])
        );
    end

    assign led_usb0_n  = act_led_n[0];
    assign led_usb1_n  = act_led_n[1];
    assign led_eth_n   = act_led_n[2];
    assign led_flash_n = act_led_n[3];
    assign led_ps2_n   = act_led_n[4];
    assign led_gpu_n   = act_led_n[5];

    // Static LEDs, all dark while the system is held in reset
    assign led_booted_n = (pc < BOOT_DONE_PC) || sys_reset;
    assign led_hdmi_n   = !select_hdmi || sys_reset;
    assign led_qspi_n   = !qspi_mode || sys_reset;

endmodule

`default_nettype wire

// File: source/system_control.sv
`timescale 1ns/1ps
`default_nettype none

module system_control
    import sysctl_cfg_pkg::*;
#(
    parameter int                  LED_MIN_CYCLES   = DEFAULT_LED_MIN_CYCLES,
    parameter int                  DTR_PULSE_CYCLES = DEFAULT_DTR_PULSE_CYCLES,
    parameter logic [PC_WIDTH-1:0] BOOT_DONE_PC     = DEFAULT_BOOT_DONE_PC
) (
    input  wire                   clk,
    input  wire                   rst_n,
    // Asynchronous board inputs
    input  wire                   nreset,
    input  wire                   btn_l_n,
    input  wire                   btn_r_n,
    input  wire                   uart0_dtr,
    input  wire                   spi1_nint,
    input  wire                   spi2_nint,
    input  wire                   spi3_int,
    input  wire                   spi4_gp,
    input  wire                   frame_drawn,
    input  wire  [1:0]            dips,
    // Already in the clk domain
    input  wire  [PC_WIDTH-1:0]   pc,
    input  wire                   usb0_cs_n,
    input  wire                   usb1_cs_n,
    input  wire                   eth_cs_n,
    input  wire                   flash_cs_n,
    input  wire                   ps2_int,
    input  wire  [VRAM_COUNT-1:0] vram_we,
    input  wire                   qspi_mode,
    output logic                  sys_reset,
    output logic                  spi1_rst,
    output logic                  spi2_rst,
    output logic                  spi3_rst_n,
    output logic                  spi1_nint_s,
    output logic                  spi2_nint_s,
    output logic                  spi3_int_s,
    output logic                  spi4_gp_s,
    output logic                  frame_drawn_s,
    output logic                  boot_mode,
    output logic                  led_debug,
    output logic                  led_usb0_n,
    output logic                  led_usb1_n,
    output logic                  led_eth_n,
    output logic                  led_flash_n,
    output logic                  led_ps2_n,
    output logic                  led_gpu_n,
    output logic                  led_booted_n,
    output logic                  led_hdmi_n,
    output logic                  led_qspi_n
);

    logic [SYNC_WIDTH-1:0] sync_raw;
    logic [SYNC_WIDTH-1:0] sync_stable;
    logic                  dtr_reset;

    // Reset pin and both buttons pull the same line
    assign sync_raw[SYNC_NRESET]      = nreset && btn_l_n && btn_r_n;
    assign sync_raw[SYNC_DTR]         = uart0_dtr;
    assign sync_raw[SYNC_SPI1_NINT]   = spi1_nint;
    assign sync_raw[SYNC_SPI2_NINT]   = spi2_nint;
    assign sync_raw[SYNC_SPI3_INT]    = spi3_int;
    assign sync_raw[SYNC_SPI4_GP]     = spi4_gp;
    assign sync_raw[SYNC_FRAME_DRAWN] = frame_drawn;
    assign sync_raw[SYNC_BOOT_MODE]   = dips[0];
    assign sync_raw[SYNC_SELECT_HDMI] = dips[1];

    input_stabilizer #(
        .WIDTH (SYNC_WIDTH)
    ) u_input_stabilizer (
        .clk        (clk),
        .rst_n      (rst_n),
        .async_in   (sync_raw),
        .stable_out (sync_stable)
    );

    assign spi1_nint_s   = sync_stable[SYNC_SPI1_NINT];
    assign spi2_nint_s   = sync_stable[SYNC_SPI2_NINT];
    assign spi3_int_s    = sync_stable[SYNC_SPI3_INT];
    assign spi4_gp_s     = sync_stable[SYNC_SPI4_GP];
    assign frame_drawn_s = sync_stable[SYNC_FRAME_DRAWN];
    assign boot_mode     = sync_stable[SYNC_BOOT_MODE];

    // Lit while a host holds the serial port open
    assign led_debug = sync_stable[SYNC_DTR];

    dtr_reset_pulse #(
        .PULSE_CYCLES (DTR_PULSE_CYCLES)
    ) u_dtr_reset_pulse (
        .clk       (clk),
        .rst_n     (rst_n),
        .dtr       (sync_stable[SYNC_DTR]),
        .dtr_reset (dtr_reset)
    );

    // Global reset
    assign sys_reset = !sync_stable[SYNC_NRESET] || dtr_reset;

    // Resets of the external peripheral chips
    assign spi1_rst   = sys_reset;
    assign spi2_rst   = sys_reset;
    assign spi3_rst_n = !sys_reset;

    status_led_bank #(
        .LED_MIN_CYCLES (LED_MIN_CYCLES),
        .BOOT_DONE_PC   (BOOT_DONE_PC)
    ) u_status_led_bank (
        .clk          (clk),
        .rst_n        (rst_n),
        .sys_reset    (sys_reset),
        .pc           (pc),
        .usb0_cs_n    (usb0_cs_n),
        .usb1_cs_n    (usb1_cs_n),
        .eth_cs_n     (eth_cs_n),
        .flash_cs_n   (flash_cs_n),
        .ps2_int      (ps2_int),
        .vram_we      (vram_we),
        .select_hdmi  (sync_stable[SYNC_SELECT_HDMI]),
        .qspi_mode    (qspi_mode),
        .led_usb0_n   (led_usb0_n),
        .led_usb1_n   (led_usb1_n),
        .led_eth_n    (led_eth_n),
        .led_flash_n  (led_flash_n),
        .led_ps2_n    (led_ps2_n),
        .led_gpu_n    (led_gpu_n),
        .led_booted_n (led_booted_n),
        .led_hdmi_n   (led_hdmi_n),
        .led_qspi_n   (led_qspi_n)
    );

endmodule

`default_nettype wire

// File: testbench/system_control_tb.sv
`timescale 1ns/1ps
`default_nettype none

module system_control_tb
    import sysctl_cfg_pkg::*;
();

    localparam int WAIT_LIMIT     = 100;
    localparam int MAX_SYNC_STEPS = 64;

    logic                  clk;
    logic                  rst_n;
    logic                  nreset;
    logic                  btn_l_n;
    logic                  btn_r_n;
    logic                  uart0_dtr;
    logic                  spi1_nint;
    logic                  spi2_nint;
    logic                  spi3_int;
    logic                  spi4_gp;
    logic                  frame_drawn;
    logic [1:0]            dips;
    logic [PC_WIDTH-1:0]   pc;
    logic                  usb0_cs_n;
    logic                  usb1_cs_n;
    logic                  eth_cs_n;
    logic                  flash_cs_n;
    logic                  ps2_int;
    logic [VRAM_COUNT-1:0] vram_we;
    logic                  qspi_mode;
    logic                  sys_reset;
    logic                  spi1_rst;
    logic                  spi2_rst;
    logic                  spi3_rst_n;
    logic                  spi1_nint_s;
    logic                  spi2_nint_s;
    logic                  spi3_int_s;
    logic                  spi4_gp_s;
    logic                  frame_drawn_s;
    logic                  boot_mode;
    logic                  led_debug;
    logic                  led_usb0_n;
    logic                  led_usb1_n;
    logic                  led_eth_n;
    logic                  led_flash_n;
    logic                  led_ps2_n;
    logic                  led_gpu_n;
    logic                  led_booted_n;
    logic                  led_hdmi_n;
    logic                  led_qspi_n;

    int    seed        = 15;
    int    pass_count  = 0;
    int    fail_count  = 0;
    int    test_errors = 0;
    string test_name;

    // Short blink and pulse lengths keep the run small
    system_control #(
        .LED_MIN_CYCLES   (8),
        .DTR_PULSE_CYCLES (12),
        .BOOT_DONE_PC     (27'h100)
    ) dut_i (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // Selector 0 is sys_reset, 1 to 6 the activity LEDs, 7 the HDMI LED
    function automatic logic probe(input int sel);
        case (sel)
            0: return sys_reset;
            1: return led_usb0_n;
            2: return led_usb1_n;
            3: return led_eth_n;
            4: return led_flash_n;
            5: return led_ps2_n;
            6: return led_gpu_n;
            7: return led_hdmi_n;
            default: return 1'bx;
        endcase
    endfunction

    function automatic logic [2:0] static_leds();
        return {led_booted_n, led_hdmi_n, led_qspi_n};
    endfunction

    function automatic logic [8:0] all_leds();
        return {led_usb0_n, led_usb1_n, led_eth_n, led_flash_n, led_ps2_n,
                led_gpu_n, static_leds()};
    endfunction

    task automatic check_int(input string msg, input int got, input int exp);
        if (got != exp) begin
            $display("Error at %0t ns: %s: %s is %0d, expected %0d",
                     $time, test_name, msg, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_bit(input string msg, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s: %s is %b, expected %b",
                     $time, test_name, msg, got, exp);
            test_errors++;
        end
    endtask

    // Counts edges after the current one until the probe reads val
    task automatic wait_for(input int sel, input logic val, input string what, output int n);
        logic hit;
        hit = 1'b0;
        n = 0;
        while (!hit && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
            @(negedge clk);
            hit = (probe(sel) === val);
        end
        if (!hit) begin
            $display("Timeout in %s: %s did not happen within %0d cycles",
                     test_name, what, WAIT_LIMIT);
            test_errors++;
            n = -1;
        end
    endtask

    task automatic set_pin(input int pin, input logic level);
        case (pin)
            0: nreset <= level;
            1: btn_l_n <= level;
            default: btn_r_n <= level;
        endcase
    endtask

    task automatic set_channel(input int ch, input int b, input logic active);
        case (ch)
            0: usb0_cs_n <= !active;
            1: usb1_cs_n <= !active;
            2: eth_cs_n <= !active;
            3: flash_cs_n <= !active;
            4: ps2_int <= active;
            default: vram_we <= active ? (VRAM_COUNT'(1) << b) : '0;
        endcase
    endtask

    // One cycle of activity, then edges counted until the LED lights
    task automatic pulse_until_lit(input int ch, input int b, output int n);
        logic lit;
        lit = 1'b0;
        n = 0;
        @(posedge clk);
        set_channel(ch, b, 1'b1);
        while (!lit && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
            if (n == 1) begin
                set_channel(ch, b, 1'b0);
            end
            @(negedge clk);
            lit = (probe(ch + 1) === 1'b0);
        end
        if (!lit) begin
            $display("Timeout in %s: activity LED never lit", test_name);
            test_errors++;
            n = -1;
        end
    endtask

    task automatic run_reset(input int release_delay, input int quiet);
        int n;
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_bit("sys_reset in reset", sys_reset, 1'b1);
        check_int("LEDs in reset", int'(all_leds()), 'h1ff);
        check_bit("led_debug in reset", led_debug, 1'b0);
        @(posedge clk);
        rst_n <= 1'b1;
        wait_for(0, 1'b0, "sys_reset release", n);
        if (n >= 0) check_int("sys_reset release delay", n, release_delay);
        // No DTR pulse may follow
        repeat (quiet) begin
            @(posedge clk);
            @(negedge clk);
            check_bit("sys_reset after release", sys_reset, 1'b0);
        end
    endtask

    task automatic run_sync(input int count, input int lat);
        logic [6:0] hist [0:MAX_SYNC_STEPS-1];
        logic [6:0] obs;
        int         r;
        int         steps;
        steps = (count > MAX_SYNC_STEPS) ? MAX_SYNC_STEPS : count;
        for (int t = 0; t < steps + lat; t++) begin
            @(posedge clk);
            if (t < steps) begin
                r = $random(seed);
                hist[t] = r[6:0];
                {dips, frame_drawn, spi4_gp, spi3_int, spi2_nint, spi1_nint} <= r[6:0];
            end
            @(negedge clk);
            // HDMI select is only visible through its LED
            obs = {!led_hdmi_n, boot_mode, frame_drawn_s, spi4_gp_s,
                   spi3_int_s, spi2_nint_s, spi1_nint_s};
            if (t >= lat) check_int("stable inputs", int'(obs), int'(hist[t - lat]));
        end
    endtask

    task automatic run_boot(input int pc_val, input int exp);
        @(posedge clk);
        pc <= PC_WIDTH'(pc_val);
        @(negedge clk);
        check_bit("led_booted_n", led_booted_n, exp[0]);
    endtask

    task automatic run_static(input int hdmi, input int qspi, input int delay,
                              input int exp_hdmi, input int exp_qspi);
        int n;
        @(posedge clk);
        dips[1] <= !hdmi[0];
        repeat (3) @(posedge clk);
        dips[1] <= hdmi[0];
        qspi_mode <= qspi[0];
        @(negedge clk);
        check_bit("led_qspi_n", led_qspi_n, exp_qspi[0]);
        wait_for(7, exp_hdmi[0], "HDMI LED change", n);
        if (n >= 0) check_int("HDMI LED delay", n, delay);
    endtask

    task automatic run_button(input int pin, input int delay);
        int n;
        @(posedge clk);
        set_pin(pin, 1'b0);
        wait_for(0, 1'b1, "sys_reset rise", n);
        if (n >= 0) check_int("reset assert delay", n, delay);
        check_bit("spi1_rst", spi1_rst, 1'b1);
        check_bit("spi2_rst", spi2_rst, 1'b1);
        check_bit("spi3_rst_n", spi3_rst_n, 1'b0);
        check_int("static LEDs in reset", int'(static_leds()), 7);
        @(posedge clk);
        set_pin(pin, 1'b1);
        wait_for(0, 1'b0, "sys_reset fall", n);
        if (n >= 0) check_int("reset release delay", n, delay);
        check_bit("spi1_rst", spi1_rst, 1'b0);
        check_bit("spi2_rst", spi2_rst, 1'b0);
        check_bit("spi3_rst_n", spi3_rst_n, 1'b1);
    endtask

    task automatic run_dtr(input int delay, input int len, input int hold);
        int n;
        // Port closed long enough to rearm
        @(posedge clk);
        uart0_dtr <= 1'b0;
        repeat (4) @(posedge clk);
        uart0_dtr <= 1'b1;
        wait_for(0, 1'b1, "DTR reset pulse", n);
        if (n >= 0) check_int("DTR pulse delay", n, delay);
        check_bit("led_debug", led_debug, 1'b1);
        check_int("static LEDs during pulse", int'(static_leds()), 7);
        wait_for(0, 1'b0, "end of DTR reset pulse", n);
        if (n >= 0) check_int("DTR pulse length", n, len);
        repeat (hold) begin
            @(posedge clk);
            @(negedge clk);
            check_bit("sys_reset while DTR held", sys_reset, 1'b0);
        end
    endtask

    task automatic run_act(input int ch, input int b, input int delay,
                           input int on_len, input int gap);
        int n;
        pulse_until_lit(ch, b, n);
        if (n >= 0) check_int("LED light delay", n, delay);
        wait_for(ch + 1, 1'b1, "end of blink", n);
        if (n >= 0) check_int("blink length", n, on_len);
        // Activity through the whole dark gap
        @(posedge clk);
        set_channel(ch, b, 1'b1);
        repeat (gap - 1) begin
            @(negedge clk);
            check_bit("LED during dark gap", probe(ch + 1), 1'b1);
            @(posedge clk);
        end
        set_channel(ch, b, 1'b0);
        repeat (2) begin
            @(posedge clk);
            @(negedge clk);
            check_bit("LED after dark gap", probe(ch + 1), 1'b1);
        end
        pulse_until_lit(ch, b, n);
        if (n >= 0) check_int("relight delay", n, delay);
        wait_for(ch + 1, 1'b1, "end of second blink", n);
        if (n >= 0) check_int("second blink length", n, on_len);
        repeat (gap + 1) @(posedge clk);
    endtask

    initial begin
        int    fd;
        int    fields;
        string line;
        string cmd;
        int    p0, p1, p2, p3, p4;
        rst_n       = 1'b0;
        nreset      = 1'b1;
        btn_l_n     = 1'b1;
        btn_r_n     = 1'b1;
        uart0_dtr   = 1'b0;
        spi1_nint   = 1'b0;
        spi2_nint   = 1'b0;
        spi3_int    = 1'b0;
        spi4_gp     = 1'b0;
        frame_drawn = 1'b0;
        dips        = 2'b00;
        pc          = '0;
        usb0_cs_n   = 1'b1;
        usb1_cs_n   = 1'b1;
        eth_cs_n    = 1'b1;
        flash_cs_n  = 1'b1;
        ps2_int     = 1'b0;
        vram_we     = '0;
        qspi_mode   = 1'b0;
        fd = $fopen("testbench/system_control_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open testbench/system_control_stimulus.txt");
            fail_count++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                fields = $sscanf(line, "%s %s %d %d %d %d %d",
                                 cmd, test_name, p0, p1, p2, p3, p4);
                // Comment and blank lines do not scan to a full record
                if (fields == 7) begin
                    test_errors = 0;
                    if (cmd == "reset") run_reset(p0, p1);
                    else if (cmd == "sync") run_sync(p0, p1);
                    else if (cmd == "boot") run_boot(p0, p1);
                    else if (cmd == "static") run_static(p0, p1, p2, p3, p4);
                    else if (cmd == "button") run_button(p0, p1);
                    else if (cmd == "dtr") run_dtr(p0, p1, p2);
                    else if (cmd == "act") run_act(p0, p1, p2, p3, p4);
                    else begin
                        $display("Unknown command %s in the stimulus file", cmd);
                        test_errors++;
                    end
                    if (test_errors == 0) begin
                        pass_count++;
                        $display("PASS: %s", test_name);
                    end else begin
                        fail_count++;
                        $display("FAIL: %s with %0d errors", test_name, test_errors);
                    end
                end
            end
            $fclose(fd);
        end
        $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && pass_count > 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/system_control_stimulus.txt
# command name p0 p1 p2 p3 p4, all values decimal, unused columns 0
# reset: release_delay quiet_cycles   sync: steps latency   boot: pc led_booted_n
# static: dips1 qspi_mode hdmi_delay led_hdmi_n led_qspi_n   button: pin delay
# button pins: 0 nreset, 1 left, 2 right   dtr: delay length hold_cycles
# act: channel vram_bit delay length gap, channels 0 usb0 1 usb1 2 eth 3 flash 4 ps2 5 gpu
reset   reset_state         2    20   0   0   0
sync    stabilizer_latency  40   2    0   0   0
boot    booted_pc_zero      0    1    0   0   0
boot    booted_below        255  1    0   0   0
boot    booted_at           256  0    0   0   0
boot    booted_above        4096 0    0   0   0
boot    booted_top          134217727 0 0 0   0
static  hdmi_qspi_off       0    0    2   1   1
static  hdmi_only           1    0    2   0   1
static  qspi_only           0    1    2   1   0
static  hdmi_qspi_on        1    1    2   0   0
button  button_nreset       0    2    0   0   0
button  button_left         1    2    0   0   0
button  button_right        2    2    0   0   0
dtr     dtr_first_open      3    12   30  0   0
dtr     dtr_second_open     3    12   30  0   0
act     usb0_blink          0    0    1   8   8
act     usb1_blink          1    0    1   8   8
act     eth_blink           2    0    1   8   8
act     flash_blink         3    0    1   8   8
act     ps2_blink           4    0    1   8   8
act     gpu_blink_we0       5    0    1   8   8
act     gpu_blink_we3       5    3    1   8   8
boot    booted_after_runs   256  0    0   0   0

// File: system_control.f
source/sysctl_cfg_pkg.sv
source/sysctl_state_pkg.sv
source/input_stabilizer.sv
source/dtr_reset_pulse.sv
source/activity_led.sv
source/status_led_bank.sv
source/system_control.sv
testbench/system_control_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the system_control testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f system_control.f \
    --top-module system_control_tb \
    -o system_control_sim

./obj_dir/system_control_sim | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "Simulation reported failures, see sim.log"
    exit 1
fi
echo "Simulation finished without failures"
